/* source/rv_core_pkg.sv */
// rv32 core shared definitions
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // store-mapped ports, never sent to memory
    localparam logic [xlen-1:0] mmio_out_addr = 32'd1000;
    localparam logic [xlen-1:0] mmio_halt_addr = 32'd1004;
    localparam logic [xlen-1:0] mmio_float_addr = 32'd1008;

    // funct3 codes
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    // funct7 codes
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt = 7'b0100000;
    localparam logic [6:0] f7_muldiv = 7'b0000001;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD
    } wb_sel_e;

    typedef enum logic [2:0] {
        FETCH, WAIT_INSTR, EXECUTE, WAIT_DATA, HALTED
    } core_state_e;

endpackage

`default_nettype wire

/* source/core_ctrl_if.sv */
// core control bundle
`timescale 1ns/1ps
`default_nettype none

interface core_ctrl_if;
    import rv_core_pkg::*;

    // register file controls
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [reg_addr_w-1:0] rd_addr;
    logic                  reg_we;

    // alu and writeback controls
    alu_op_e               alu_op;
    logic                  operand_a_pc;
    logic                  operand_b_imm;
    logic [xlen-1:0]       imm;
    wb_sel_e               wb_sel;

    // pc controls
    logic                  pc_step;
    logic                  pc_load;
    logic [xlen-1:0]       branch_target;

    modport fsm (output rs1_addr, rs2_addr, rd_addr, reg_we, alu_op, operand_a_pc,
                 operand_b_imm, imm, wb_sel, pc_step, pc_load, branch_target);
    modport pc_side (input pc_step, pc_load, branch_target);
    modport rf_side (input rs1_addr, rs2_addr, rd_addr, reg_we);
    modport alu_side (input alu_op, operand_a_pc, operand_b_imm, imm, wb_sel);

endinterface

`default_nettype wire

/* source/alu.sv */
// arithmetic and logic unit
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rv_core_pkg::xlen-1:0] rs1_data,
    input  logic [rv_core_pkg::xlen-1:0] rs2_data,
    input  logic [rv_core_pkg::xlen-1:0] pc,
    input  logic [rv_core_pkg::xlen-1:0] load_data,
    core_ctrl_if.alu_side                ctrl,
    output logic [rv_core_pkg::xlen-1:0] alu_result,
    output logic [rv_core_pkg::xlen-1:0] wb_data
);
    import rv_core_pkg::*;

    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [4:0]      shamt;

    // auipc takes pc, immediates replace rs2
    assign operand_a = ctrl.operand_a_pc ? pc : rs1_data;
    assign operand_b = ctrl.operand_b_imm ? ctrl.imm : rs2_data;
    assign shamt = operand_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_result = operand_a + operand_b;
            ALU_SUB:    alu_result = operand_a - operand_b;
            ALU_SLT:    alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU:   alu_result = {31'b0, operand_a < operand_b};
            ALU_AND:    alu_result = operand_a & operand_b;
            ALU_OR:     alu_result = operand_a | operand_b;
            ALU_XOR:    alu_result = operand_a ^ operand_b;
            ALU_SLL:    alu_result = operand_a << shamt;
            ALU_SRL:    alu_result = operand_a >> shamt;
            // sign bit fills from the left
            ALU_SRA:    alu_result = $signed(operand_a) >>> shamt;
            // low word of the product
            ALU_MUL:    alu_result = operand_a * operand_b;
            ALU_PASS_B: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    assign wb_data = (ctrl.wb_sel == WB_LOAD) ? load_data : alu_result;

endmodule

`default_nettype wire

/* source/pc_counter.sv */
// program counter
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
    input  logic                         clk,
    input  logic                         rst,
    core_ctrl_if.pc_side                 ctrl,
    output logic [rv_core_pkg::xlen-1:0] pc
);
    import rv_core_pkg::*;

    logic [xlen-1:0] pc_next;

    // taken branch wins over a plain step
    always_comb begin
        pc_next = pc;
        if (ctrl.pc_load) begin
            pc_next = ctrl.branch_target;
        end else if (ctrl.pc_step) begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* source/reg_file.sv */
// integer register file
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [rv_core_pkg::xlen-1:0] wr_data,
    core_ctrl_if.rf_side                 ctrl,
    output logic [rv_core_pkg::xlen-1:0] rs1_data,
    output logic [rv_core_pkg::xlen-1:0] rs2_data
);
    import rv_core_pkg::*;

    logic [xlen-1:0] regs [0:31];

    // x0 is hardwired to zero
    assign rs1_data = (ctrl.rs1_addr == '0) ? '0 : regs[ctrl.rs1_addr];
    assign rs2_data = (ctrl.rs2_addr == '0) ? '0 : regs[ctrl.rs2_addr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_we && ctrl.rd_addr != '0) begin
            regs[ctrl.rd_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* source/core_fsm.sv */
// instruction sequencer and decoder
`timescale 1ns/1ps
`default_nettype none

module core_fsm (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [rv_core_pkg::xlen-1:0] mem_rd_data,
    input  logic                         mem_ack,
    input  logic [rv_core_pkg::xlen-1:0] pc,
    input  logic [rv_core_pkg::xlen-1:0] rs1_data,
    input  logic [rv_core_pkg::xlen-1:0] rs2_data,
    input  logic [rv_core_pkg::xlen-1:0] alu_result,
    output logic [rv_core_pkg::xlen-1:0] mem_addr,
    output logic [rv_core_pkg::xlen-1:0] mem_wr_data,
    output logic                         mem_rd_req,
    output logic                         mem_wr_req,
    output logic [rv_core_pkg::xlen-1:0] out,
    output logic                         out_valid,
    output logic                         out_float_valid,
    output logic                         halt,
    core_ctrl_if.fsm                     ctrl
);
    import rv_core_pkg::*;

    core_state_e     state;
    core_state_e     next_state;
    logic [xlen-1:0] instr;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic            legal;
    logic            branch_taken;

    // instruction fields
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign ctrl.rd_addr = instr[11:7];
    assign ctrl.rs1_addr = instr[19:15];
    assign ctrl.rs2_addr = instr[24:20];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};

    // beq takes on equal, bne on not equal
    assign branch_taken = (rs1_data == rs2_data) ^ (funct3 == f3_bne);
    assign ctrl.branch_target = pc + b_imm;

    assign out = rs2_data;
    assign mem_wr_data = rs2_data;
    assign halt = (state == HALTED);

    // operand and operation decode
    always_comb begin
        legal = 1'b1;
        ctrl.alu_op = ALU_ADD;
        ctrl.operand_a_pc = 1'b0;
        ctrl.operand_b_imm = 1'b1;
        ctrl.imm = i_imm;
        case (opcode)
            OP_IMM: legal = (funct3 == f3_add_sub);
            OP: begin
                ctrl.operand_b_imm = 1'b0;
                if (funct7 == f7_muldiv && funct3 == f3_add_sub) begin
                    ctrl.alu_op = ALU_MUL;
                end else if (funct7 == f7_alt && funct3 == f3_add_sub) begin
                    ctrl.alu_op = ALU_SUB;
                end else if (funct7 == f7_alt && funct3 == f3_srl_sra) begin
                    ctrl.alu_op = ALU_SRA;
                end else if (funct7 == f7_base) begin
                    case (funct3)
                        f3_add_sub: ctrl.alu_op = ALU_ADD;
                        f3_sll:     ctrl.alu_op = ALU_SLL;
                        f3_slt:     ctrl.alu_op = ALU_SLT;
                        f3_sltu:    ctrl.alu_op = ALU_SLTU;
                        f3_xor:     ctrl.alu_op = ALU_XOR;
                        f3_srl_sra: ctrl.alu_op = ALU_SRL;
                        f3_or:      ctrl.alu_op = ALU_OR;
                        f3_and:     ctrl.alu_op = ALU_AND;
                        default:    legal = 1'b0;
                    endcase
                end else begin
                    legal = 1'b0;
                end
            end
            LOAD: legal = (funct3 == f3_word);
            STORE: begin
                ctrl.imm = s_imm;
                legal = (funct3 == f3_word);
            end
            BRANCH: legal = (funct3 == f3_beq) || (funct3 == f3_bne);
            LUI: begin
                ctrl.alu_op = ALU_PASS_B;
                ctrl.imm = u_imm;
            end
            AUIPC: begin
                ctrl.operand_a_pc = 1'b1;
                ctrl.imm = u_imm;
            end
            default: legal = 1'b0;
        endcase
    end

    // sequencing and strobes
    always_comb begin
        next_state = state;
        mem_addr = alu_result;
        mem_rd_req = 1'b0;
        mem_wr_req = 1'b0;
        out_valid = 1'b0;
        out_float_valid = 1'b0;
        ctrl.reg_we = 1'b0;
        ctrl.wb_sel = WB_ALU;
        ctrl.pc_step = 1'b0;
        ctrl.pc_load = 1'b0;
        case (state)
            FETCH: begin
                mem_addr = pc;
                mem_rd_req = 1'b1;
                next_state = WAIT_INSTR;
            end
            WAIT_INSTR: begin
                if (mem_ack) begin
                    next_state = EXECUTE;
                end
            end
            EXECUTE: begin
                next_state = FETCH;
                if (!legal) begin
                    next_state = HALTED;
                end else if (opcode == LOAD) begin
                    mem_rd_req = 1'b1;
                    next_state = WAIT_DATA;
                end else if (opcode == STORE) begin
                    if (alu_result == mmio_halt_addr) begin
                        next_state = HALTED;
                    end else if (alu_result == mmio_out_addr) begin
                        out_valid = 1'b1;
                        ctrl.pc_step = 1'b1;
                    end else if (alu_result == mmio_float_addr) begin
                        out_float_valid = 1'b1;
                        ctrl.pc_step = 1'b1;
                    end else begin
                        mem_wr_req = 1'b1;
                        next_state = WAIT_DATA;
                    end
                end else if (opcode == BRANCH) begin
                    ctrl.pc_load = branch_taken;
                    ctrl.pc_step = !branch_taken;
                end else begin
                    ctrl.reg_we = 1'b1;
                    ctrl.pc_step = 1'b1;
                end
            end
            WAIT_DATA: begin
                if (mem_ack) begin
                    // only loads write back
                    ctrl.reg_we = (opcode == LOAD);
                    ctrl.wb_sel = WB_LOAD;
                    ctrl.pc_step = 1'b1;
                    next_state = FETCH;
                end
            end
            default: next_state = HALTED;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_INSTR && mem_ack) begin
            instr <= mem_rd_data;
        end
    end

endmodule

`default_nettype wire

/* source/rv_core_top.sv */
// multicycle rv32 core
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [rv_core_pkg::xlen-1:0] mem_rd_data,
    input  logic                         mem_ack,
    output logic [rv_core_pkg::xlen-1:0] mem_addr,
    output logic [rv_core_pkg::xlen-1:0] mem_wr_data,
    output logic                         mem_rd_req,
    output logic                         mem_wr_req,
    output logic [rv_core_pkg::xlen-1:0] out,
    output logic                         out_valid,
    output logic                         out_float_valid,
    output logic                         halt
);
    import rv_core_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;

    core_ctrl_if ctrl ();

    core_fsm i_core_fsm (
        .clk             (clk),
        .rst             (rst),
        .mem_rd_data     (mem_rd_data),
        .mem_ack         (mem_ack),
        .pc              (pc),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .alu_result      (alu_result),
        .mem_addr        (mem_addr),
        .mem_wr_data     (mem_wr_data),
        .mem_rd_req      (mem_rd_req),
        .mem_wr_req      (mem_wr_req),
        .out             (out),
        .out_valid       (out_valid),
        .out_float_valid (out_float_valid),
        .halt            (halt),
        .ctrl            (ctrl.fsm)
    );

    pc_counter i_pc_counter (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl.pc_side),
        .pc   (pc)
    );

    // write data comes back through the alu writeback mux
    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (wb_data),
        .ctrl     (ctrl.rf_side),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu i_alu (
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (pc),
        .load_data  (mem_rd_data),
        .ctrl       (ctrl.alu_side),
        .alu_result (alu_result),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

/* verif/core_checker.sv */
// output port checker
`timescale 1ns/1ps
`default_nettype none

module core_checker (
    input wire logic        clk,
    input wire logic [31:0] out,
    input wire logic        out_valid,
    input wire logic        out_float_valid,
    input wire logic        halt
);
    // bit 32 marks a float port value
    logic [32:0] expected_q[$];
    string       test_name = "none";
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_errors = 0;

    task automatic push_expected(input logic [32:0] value);
        expected_q.push_back(value);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        expected_q.delete();
    endtask

    task automatic end_test();
        if (!halt) begin
            $display("test %s ended without the core halting", test_name);
            test_errors++;
        end
        if (expected_q.size() != 0) begin
            $display("test %s: core halted with %0d values still expected", test_name,
                     expected_q.size());
            test_errors++;
        end
        errors += test_errors;
        tests++;
        $display("test %s done, %0d errors", test_name, test_errors);
    endtask

    task automatic report_counts();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    endtask

    always @(posedge clk) begin
        logic [32:0] exp_v;
        if (out_valid || out_float_valid) begin
            checks++;
            if (expected_q.size() == 0) begin
                $display("test %s: output pulse with no value expected", test_name);
                test_errors++;
            end else begin
                exp_v = expected_q.pop_front();
                if (exp_v[32] != out_float_valid) begin
                    $display("test %s: value appeared on the wrong output port", test_name);
                    test_errors++;
                end else if (exp_v[31:0] != out) begin
                    $display("FAILED %s expected %h actual %h", test_name, exp_v[31:0], out);
                    test_errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/rv_core_sva.sv */
// core protocol assertions
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva (
    input wire logic clk,
    input wire logic rst,
    input wire logic mem_rd_req,
    input wire logic mem_wr_req,
    input wire logic mem_ack,
    input wire logic out_valid,
    input wire logic out_float_valid,
    input wire logic halt
);
    logic pending;

    // one access outstanding until its ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= (pending && !mem_ack) || mem_rd_req || mem_wr_req;
        end
    end

    a_single_req: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req && mem_wr_req)) else $error("read and write request together");
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        pending |-> !(mem_rd_req || mem_wr_req)) else $error("request while access pending");
    a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
        halt |=> halt) else $error("halt dropped without reset");
    a_one_port: assert property (@(posedge clk) disable iff (rst)
        !(out_valid && out_float_valid)) else $error("both output strobes high");

endmodule

bind rv_core_top rv_core_sva i_rv_core_sva (.*);

`default_nettype wire

/* verif/tb_top.sv */
// core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    // budget of executed instructions at 13 cycles worst case each
    localparam int instr_budget = 160;
    localparam int cycle_limit = instr_budget * 13 + 400;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] mem_rd_data;
    logic        mem_ack;
    logic [31:0] mem_addr;
    logic [31:0] mem_wr_data;
    logic        mem_rd_req;
    logic        mem_wr_req;
    logic [31:0] out;
    logic        out_valid;
    logic        out_float_valid;
    logic        halt;
    logic [31:0] mem [0:255];
    logic [7:0]  wp;
    int          seed;
    int          cycle_count = 0;

    always #4 clk = ~clk;

    rv_core_top i_rv_core_top (
        .clk             (clk),
        .rst             (rst),
        .mem_rd_data     (mem_rd_data),
        .mem_ack         (mem_ack),
        .mem_addr        (mem_addr),
        .mem_wr_data     (mem_wr_data),
        .mem_rd_req      (mem_rd_req),
        .mem_wr_req      (mem_wr_req),
        .out             (out),
        .out_valid       (out_valid),
        .out_float_valid (out_float_valid),
        .halt            (halt)
    );

    core_checker i_checker (
        .clk             (clk),
        .out             (out),
        .out_valid       (out_valid),
        .out_float_valid (out_float_valid),
        .halt            (halt)
    );

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    // funct7 and funct3 of the eleven register ops in ref_alu order
    function automatic logic [9:0] op_fields(input int op);
        case (op)
            1:       return {7'b0100000, 3'b000};
            2:       return {7'b0000000, 3'b010};
            3:       return {7'b0000000, 3'b011};
            4:       return {7'b0000000, 3'b111};
            5:       return {7'b0000000, 3'b110};
            6:       return {7'b0000000, 3'b100};
            7:       return {7'b0000000, 3'b001};
            8:       return {7'b0000000, 3'b101};
            9:       return {7'b0100000, 3'b101};
            10:      return {7'b0000001, 3'b000};
            default: return {7'b0000000, 3'b000};
        endcase
    endfunction

    function automatic logic [31:0] ref_alu(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            1:       return a - b;
            2:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3:       return (a < b) ? 32'd1 : 32'd0;
            4:       return a & b;
            5:       return a | b;
            6:       return a ^ b;
            7:       return a << b[4:0];
            8:       return a >> b[4:0];
            9:       return $unsigned($signed(a) >>> b[4:0]);
            10:      return a * b;
            default: return a + b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[wp] = word;
        wp = wp + 8'd1;
    endtask

    // lui plus addi with the upper part rounded for the sign of the low 12 bits
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(enc_u(7'b0110111, rd, upper[31:12]));
        emit(enc_i(7'b0010011, 3'b000, rd, rd, value[11:0]));
    endtask

    task automatic new_program(input string name);
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i[7:0]] = 32'hdead0000 ^ {22'b0, i[7:0], 2'b00};
        end
        wp = 8'd0;
        i_checker.start_test(name);
    endtask

    task automatic run_program();
        // halt store at the end of every program
        emit(enc_s(5'd0, 5'd0, 12'd1004));
        repeat (5) @(negedge clk);
        rst = 1'b0;
        while (!halt) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        i_checker.end_test();
    endtask

    // ack follows the request by 1 to 4 cycles with read data held until then
    task automatic serve_memory();
        int          lat;
        logic        pending;
        logic        start;
        logic [31:0] rd_word;
        pending = 1'b0;
        lat = 0;
        rd_word = '0;
        forever begin
            // a request counts at the rising edge that ends its cycle
            @(posedge clk);
            start = !rst && !pending && (mem_rd_req || mem_wr_req);
            if (start) begin
                rd_word = mem[mem_addr[9:2]];
                if (mem_wr_req) begin
                    mem[mem_addr[9:2]] = mem_wr_data;
                end
            end
            @(negedge clk);
            mem_ack = 1'b0;
            if (rst) begin
                pending = 1'b0;
            end else begin
                if (start) begin
                    mem_rd_data = rd_word;
                    lat = 1 + int'($unsigned($random(seed)) % 4);
                    pending = 1'b1;
                end
                if (pending) begin
                    if (lat == 1) begin
                        mem_ack = 1'b1;
                        pending = 1'b0;
                    end else begin
                        lat = lat - 1;
                    end
                end
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, core did not halt", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] auipc_pc;
        logic [9:0]  fields;
        seed = 32'h52d2347d;
        rst = 1'b1;
        mem_ack = 1'b0;
        mem_rd_data = '0;
        wp = 8'd0;
        fork
            serve_memory();
        join_none

        new_program("alu_reg_ops");
        for (int k = 0; k < 11; k++) begin
            a = $random(seed);
            b = $random(seed);
            // negative first operand tells signed slt and sra apart from unsigned
            if (k == 2 || k == 9) begin
                a[31] = 1'b1;
                b[31] = 1'b0;
                b[4] = 1'b1;
            end
            fields = op_fields(k);
            load_const(5'd1, a);
            load_const(5'd2, b);
            emit(enc_r(fields[9:3], 5'd2, 5'd1, fields[2:0], 5'd3));
            emit(enc_s(5'd3, 5'd0, 12'd1000));
            i_checker.push_expected({1'b0, ref_alu(k, a, b)});
        end
        run_program();

        new_program("imm_lui_auipc");
        emit(enc_i(7'b0010011, 3'b000, 5'd1, 5'd0, 12'hffb));
        emit(enc_i(7'b0010011, 3'b000, 5'd2, 5'd1, 12'(-2000)));
        emit(enc_u(7'b0110111, 5'd3, 20'habcde));
        auipc_pc = {22'b0, wp, 2'b00};
        emit(enc_u(7'b0010111, 5'd4, 20'h12345));
        for (int r = 1; r < 5; r++) begin
            emit(enc_s(5'(r), 5'd0, 12'd1000));
        end
        v = ref_alu(0, 32'd0, 32'hfffffffb);
        i_checker.push_expected({1'b0, v});
        i_checker.push_expected({1'b0, ref_alu(0, v, 32'hfffff830)});
        i_checker.push_expected({1'b0, 32'habcde000});
        i_checker.push_expected({1'b0, ref_alu(0, auipc_pc, 32'h12345000)});
        run_program();

        new_program("store_load");
        a = $random(seed);
        b = $random(seed);
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(enc_s(5'd1, 5'd0, 12'd512));
        emit(enc_s(5'd2, 5'd0, 12'd516));
        emit(enc_i(7'b0000011, 3'b010, 5'd3, 5'd0, 12'd512));
        emit(enc_i(7'b0000011, 3'b010, 5'd4, 5'd0, 12'd516));
        emit(enc_i(7'b0000011, 3'b010, 5'd0, 5'd0, 12'd512));
        emit(enc_s(5'd3, 5'd0, 12'd1000));
        emit(enc_s(5'd4, 5'd0, 12'd1000));
        emit(enc_s(5'd0, 5'd0, 12'd1000));
        i_checker.push_expected({1'b0, a});
        i_checker.push_expected({1'b0, b});
        i_checker.push_expected(33'd0);
        run_program();

        new_program("branch_loop");
        emit(enc_i(7'b0010011, 3'b000, 5'd1, 5'd0, 12'd5));
        emit(enc_s(5'd1, 5'd0, 12'd1000));
        emit(enc_i(7'b0010011, 3'b000, 5'd1, 5'd1, 12'hfff));
        emit(enc_b(3'b001, 5'd1, 5'd0, 13'(-8)));
        emit(enc_i(7'b0010011, 3'b000, 5'd5, 5'd0, 12'd77));
        emit(enc_b(3'b000, 5'd0, 5'd0, 13'd8));
        emit(enc_s(5'd1, 5'd0, 12'd1000));
        emit(enc_s(5'd5, 5'd0, 12'd1000));
        v = 32'd5;
        while (v != 32'd0) begin
            i_checker.push_expected({1'b0, v});
            v = ref_alu(0, v, 32'hffffffff);
        end
        i_checker.push_expected({1'b0, 32'd77});
        run_program();

        new_program("float_and_halt");
        a = $random(seed);
        load_const(5'd1, a);
        emit(enc_s(5'd1, 5'd0, 12'd1008));
        emit(enc_s(5'd0, 5'd0, 12'd1004));
        emit(enc_s(5'd1, 5'd0, 12'd1000));
        i_checker.push_expected({1'b1, a});
        run_program();

        new_program("illegal_opcode");
        a = $random(seed);
        load_const(5'd1, a);
        emit(enc_s(5'd1, 5'd0, 12'd1000));
        emit(32'hffffffff);
        emit(enc_s(5'd1, 5'd0, 12'd1000));
        i_checker.push_expected({1'b0, a});
        run_program();

        i_checker.report_counts();
        if (i_checker.errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/rv_core_pkg.sv
source/core_ctrl_if.sv
source/alu.sv
source/pc_counter.sv
source/reg_file.sv
source/core_fsm.sv
source/rv_core_top.sv
verif/core_checker.sv
verif/rv_core_sva.sv
verif/tb_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f tb.f -Mdir obj_dir -o sim_tb \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "simulation FAILED"; exit 1; }
echo "simulation passed" && exit 0
